//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_gpu -f sources.f -o tb_gpu_sim &&
{ ./obj_dir/tb_gpu_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log; } &&
cat sim.log &&
! grep -q "TEST FAILED" sim.log

//--- sources.f
+incdir+src
src/gpu_pkg.sv
src/pixel_if.sv
src/gpu_cmd_regs.sv
src/gpu_line_drawer.sv
src/gpu_clear_engine.sv
src/gpu_bus_arbiter.sv
src/gpu.sv
verif/gpu_checker.sv
verif/tb_gpu.sv

//--- src/gpu.sv
`timescale 1ns/1ps

`include "gpu_consts.svh"

module gpu import gpu_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	// host command port
	input  logic                   psel,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	// frame buffer write port
	output logic [`GPU_ADDR_W-1:0] haddr,
	output logic [`GPU_DATA_W-1:0] hwdata,
	output logic                   hwrite,
	input  logic                   hready
);

	point_t start_pt;
	point_t end_pt;
	color_t color;
	logic   front;
	logic   draw_go;
	logic   clear_go;
	logic   line_busy;
	logic   clear_busy;

	pixel_if line_pix();
	pixel_if clear_pix();

	gpu_cmd_regs cmd_regs_inst
	(
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.start_pt   (start_pt),
		.end_pt     (end_pt),
		.color      (color),
		.front      (front),
		.draw_go    (draw_go),
		.clear_go   (clear_go),
		.line_busy  (line_busy),
		.clear_busy (clear_busy)
	);

	gpu_line_drawer line_drawer_inst
	(
		.clk      (clk),
		.reset    (reset),
		.go       (draw_go),
		.start_pt (start_pt),
		.end_pt   (end_pt),
		.color    (color),
		.busy     (line_busy),
		.pix      (line_pix.engine)
	);

	gpu_clear_engine clear_engine_inst
	(
		.clk   (clk),
		.reset (reset),
		.go    (clear_go),
		.busy  (clear_busy),
		.pix   (clear_pix.engine)
	);

	// both engines share the single write port
	gpu_bus_arbiter bus_arbiter_inst
	(
		.clk       (clk),
		.reset     (reset),
		.line_pix  (line_pix.arbiter),
		.clear_pix (clear_pix.arbiter),
		.front     (front),
		.haddr     (haddr),
		.hwdata    (hwdata),
		.hwrite    (hwrite),
		.hready    (hready)
	);

endmodule

//--- src/gpu_bus_arbiter.sv
`timescale 1ns/1ps

`include "gpu_consts.svh"

module gpu_bus_arbiter import gpu_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	pixel_if.arbiter               line_pix,
	pixel_if.arbiter               clear_pix,
	input  logic                   front,
	output logic [`GPU_ADDR_W-1:0] haddr,
	output logic [`GPU_DATA_W-1:0] hwdata,
	output logic                   hwrite,
	input  logic                   hready
);

	logic                   prefer_clear; // round-robin pointer
	logic                   slot_free;
	logic                   grant_line;
	logic                   grant_clear;
	point_t                 sel_pos;
	color_t                 sel_color;
	logic [31:0]            pix_index;
	logic [`GPU_ADDR_W-1:0] back_base;
	logic [`GPU_ADDR_W-1:0] addr_next;

	// the output beat is either empty or retiring on this edge
	assign slot_free = !hwrite || hready;

	assign grant_line  = slot_free && line_pix.req && (!clear_pix.req || !prefer_clear);
	assign grant_clear = slot_free && clear_pix.req && (!line_pix.req || prefer_clear);

	assign line_pix.grant  = grant_line;
	assign clear_pix.grant = grant_clear;

	assign sel_pos   = grant_clear ? clear_pix.pos : line_pix.pos;
	assign sel_color = grant_clear ? clear_pix.color : line_pix.color;

	//////////////////////////////////////////////////
	// back buffer addressing
	//////////////////////////////////////////////////

	assign pix_index = 32'(sel_pos.y) * `GPU_WIDTH + 32'(sel_pos.x);
	assign back_base = front ? `GPU_BUF0_BASE : `GPU_BUF1_BASE;
	assign addr_next = back_base + `GPU_ADDR_W'({pix_index[29:0], 2'b00});

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prefer_clear <= 1'b0;
			hwrite       <= 1'b0;
			haddr        <= '0;
			hwdata       <= '0;
		end
		else
		begin
			if (grant_line)
				prefer_clear <= 1'b1;
			else if (grant_clear)
				prefer_clear <= 1'b0;

			if (grant_line || grant_clear)
			begin
				hwrite <= 1'b1;
				haddr  <= addr_next;
				hwdata <= `GPU_DATA_W'(sel_color); // top byte stays zero
			end
			else if (hready)
				hwrite <= 1'b0;
		end
	end

endmodule

//--- src/gpu_clear_engine.sv
`timescale 1ns/1ps

`include "gpu_consts.svh"

module gpu_clear_engine import gpu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    go,
	output logic    busy,
	pixel_if.engine pix
);

	localparam logic [8:0] LAST_X = 9'(`GPU_WIDTH - 1);
	localparam logic [7:0] LAST_Y = 8'(`GPU_HEIGHT - 1);

	logic   active;
	point_t cur;

	assign busy      = active;
	assign pix.req   = active;
	assign pix.pos   = cur;
	assign pix.color = '0; // cleared pixels are black

	always_ff @(posedge clk)
	begin
		if (reset)
			active <= 1'b0;
		else if (!active)
			active <= go;
		else if (pix.grant && (cur.x == LAST_X) && (cur.y == LAST_Y))
			active <= 1'b0;
	end

	// raster scan, x runs fastest
	always_ff @(posedge clk)
	begin
		if (!active)
			cur <= '0;
		else if (pix.grant)
		begin
			if (cur.x == LAST_X)
			begin
				cur.x <= 9'd0;
				cur.y <= cur.y + 8'd1;
			end
			else
				cur.x <= cur.x + 9'd1;
		end
	end

endmodule

//--- src/gpu_cmd_regs.sv
`timescale 1ns/1ps

module gpu_cmd_regs import gpu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output point_t      start_pt,
	output point_t      end_pt,
	output color_t      color,
	output logic        front,
	output logic        draw_go,
	output logic        clear_go,
	input  logic        line_busy,
	input  logic        clear_busy
);

	logic        armed; // set once psel has been seen low
	logic        fire;
	gpu_opcode_e opcode;
	point_t      cmd_pt;
	status_t     status;

	assign opcode = gpu_opcode_e'(pwdata[26:24]);
	assign cmd_pt = point_t'(pwdata[16:0]);
	assign fire   = psel && pwrite && armed; // one command per select, however long psel stays up

	// engine launches are combinational so busy shows up one cycle after the command
	assign draw_go  = fire && (opcode == OP_DRAW) && !line_busy;
	assign clear_go = fire && (opcode == OP_CLEAR) && !clear_busy;

	assign status.front      = front;
	assign status.clear_busy = clear_busy;
	assign status.line_busy  = line_busy;

	assign prdata = (psel && !pwrite) ? 32'(status) : 32'd0;

	//////////////////////////////////////////////////
	// command register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			armed    <= 1'b1;
			start_pt <= '0;
			end_pt   <= '0;
			color    <= '0;
			front    <= 1'b0;
		end
		else
		begin
			if (fire)
				armed <= 1'b0;
			else if (!psel)
				armed <= 1'b1;

			if (fire)
			begin
				case (opcode)
					OP_SET_START:  start_pt <= cmd_pt;
					OP_SET_END:    end_pt <= cmd_pt;
					OP_SET_COLOR:  color <= pwdata[23:0];
					OP_MOVE_START:
					begin
						start_pt.x <= start_pt.x + cmd_pt.x; // both fields wrap
						start_pt.y <= start_pt.y + cmd_pt.y;
					end
					OP_MOVE_END:
					begin
						end_pt.x <= end_pt.x + cmd_pt.x;
						end_pt.y <= end_pt.y + cmd_pt.y;
					end
					OP_FLIP:
					begin
						// swapping under a running engine would split its pixels over two buffers
						if (!line_busy && !clear_busy)
							front <= ~front;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- src/gpu_consts.svh
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// frame geometry in pixels
`define GPU_WIDTH      320
`define GPU_HEIGHT     240

// byte base of each frame buffer, one 32-bit word per pixel
`define GPU_BUF0_BASE  32'h0000_0000
`define GPU_BUF1_BASE  32'h0004_B000

`define GPU_ADDR_W     32
`define GPU_DATA_W     32

`endif

//--- src/gpu_line_drawer.sv
`timescale 1ns/1ps

module gpu_line_drawer import gpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     go,
	input  point_t   start_pt,
	input  point_t   end_pt,
	input  color_t   color,
	output logic     busy,
	pixel_if.engine  pix
);

	line_state_e        state;
	point_t             cur;
	point_t             end_q;
	color_t             col_q;
	logic               sx; // high when x steps down
	logic               sy;
	logic signed [11:0] dx;
	logic signed [11:0] dy;
	logic signed [11:0] err;
	logic signed [11:0] diff_x;
	logic signed [11:0] diff_y;
	logic signed [11:0] abs_x;
	logic signed [11:0] abs_y;
	logic signed [11:0] e2;
	logic               step_x;
	logic               step_y;

	assign diff_x = $signed({3'b000, end_q.x}) - $signed({3'b000, cur.x});
	assign diff_y = $signed({4'b0000, end_q.y}) - $signed({4'b0000, cur.y});
	assign abs_x  = diff_x[11] ? -diff_x : diff_x;
	assign abs_y  = diff_y[11] ? -diff_y : diff_y;

	assign e2     = err <<< 1;
	assign step_x = e2 > -dy;
	assign step_y = e2 < dx;

	assign busy      = (state != LINE_IDLE);
	assign pix.req   = (state == LINE_RUN);
	assign pix.pos   = cur;
	assign pix.color = col_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= LINE_IDLE;
		else
		begin
			case (state)
				LINE_IDLE:
				begin
					if (go)
						state <= LINE_SETUP;
				end
				LINE_SETUP: state <= LINE_RUN;
				LINE_RUN:
				begin
					if (pix.grant && (cur == end_q))
						state <= LINE_IDLE; // end point has gone out
				end
				default: state <= LINE_IDLE;
			endcase
		end
	end

	// datapath, loaded on go and stepped on every grant
	always_ff @(posedge clk)
	begin
		if ((state == LINE_IDLE) && go)
		begin
			cur   <= start_pt;
			end_q <= end_pt;
			col_q <= color;
		end
		else if (state == LINE_SETUP)
		begin
			dx  <= abs_x;
			dy  <= abs_y;
			sx  <= diff_x[11];
			sy  <= diff_y[11];
			err <= abs_x - abs_y;
		end
		else if ((state == LINE_RUN) && pix.grant && (cur != end_q))
		begin
			err <= err - (step_x ? dy : 12'sd0) + (step_y ? dx : 12'sd0);
			if (step_x)
				cur.x <= sx ? cur.x - 9'd1 : cur.x + 9'd1;
			if (step_y)
				cur.y <= sy ? cur.y - 8'd1 : cur.y + 8'd1;
		end
	end

endmodule

//--- src/gpu_pkg.sv
package gpu_pkg;

	// host command opcodes, bits 26:24 of the command word
	typedef enum logic [2:0]
	{
		OP_CLEAR      = 3'd0,
		OP_SET_START  = 3'd1,
		OP_SET_END    = 3'd2,
		OP_SET_COLOR  = 3'd3,
		OP_MOVE_START = 3'd4,
		OP_MOVE_END   = 3'd5,
		OP_DRAW       = 3'd6,
		OP_FLIP       = 3'd7
	} gpu_opcode_e;

	typedef struct packed
	{
		logic [8:0] x; // bits 16:8 of a point word
		logic [7:0] y;
	} point_t;

	typedef logic [23:0] color_t; // rgb, red in the top byte

	typedef enum logic [1:0]
	{
		LINE_IDLE,
		LINE_SETUP,
		LINE_RUN
	} line_state_e;

	typedef struct packed
	{
		logic front;
		logic clear_busy;
		logic line_busy;
	} status_t;

endpackage

//--- src/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if import gpu_pkg::*; ();

	logic   req;   // held until grant
	point_t pos;
	color_t color;
	logic   grant; // the pixel moves in this cycle

	modport engine
	(
		output req,
		output pos,
		output color,
		input  grant
	);

	modport arbiter
	(
		input  req,
		input  pos,
		input  color,
		output grant
	);

endinterface

//--- verif/gpu_checker.sv
`timescale 1ns/1ps

`include "gpu_consts.svh"

module gpu_checker
(
	input logic        clk,
	input logic        reset,
	input logic [31:0] haddr,
	input logic [31:0] hwdata,
	input logic        hwrite,
	input logic        hready
);

	// both frame buffers, one word per pixel
	localparam logic [31:0] ADDR_LIMIT = 32'(2 * `GPU_WIDTH * `GPU_HEIGHT * 4);

	// a stalled beat keeps its address and data
	hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
		(hwrite && !hready) |=> (hwrite && $stable(haddr) && $stable(hwdata)))
		else $error("bus write changed while hready was low");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !hwrite)
		else $error("hwrite high in the cycle after reset");

	addr_in_range: assert property (@(posedge clk) disable iff (reset)
		hwrite |-> ((haddr[1:0] == 2'b00) && (haddr < ADDR_LIMIT)))
		else $error("write address %h is unaligned or outside both buffers", haddr);

endmodule

//--- verif/tb_gpu.sv
`timescale 1ns/1ps

`include "gpu_consts.svh"

module tb_gpu import gpu_pkg::*; ();

	localparam int FRAME_PIXELS = `GPU_WIDTH * `GPU_HEIGHT;
	localparam int WAIT_LIMIT   = 500000; // status polls to allow for a stalled full clear

	logic                   clk;
	logic                   reset;
	logic                   psel;
	logic                   pwrite;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic [`GPU_ADDR_W-1:0] haddr;
	logic [`GPU_DATA_W-1:0] hwdata;
	logic                   hwrite;
	logic                   hready;

	logic        stall_mode; // random hready when set
	logic        exp_front;
	int          check_errors;
	int          timeouts;
	int          log_epoch;
	int          seen_epoch;
	int          total_writes;
	int          draw_writes;
	int          clear_writes;
	int          top_byte_writes; // writes with anything in hwdata[31:24]
	color_t      draw_mem [logic [31:0]]; // nonzero writes by address
	bit          clear_mem [logic [31:0]];
	logic [31:0] ref_addr [$];

	gpu gpu_inst
	(
		.clk    (clk),
		.reset  (reset),
		.psel   (psel),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.haddr  (haddr),
		.hwdata (hwdata),
		.hwrite (hwrite),
		.hready (hready)
	);

	bind gpu gpu_checker checker_inst
	(
		.clk    (clk),
		.reset  (reset),
		.haddr  (haddr),
		.hwdata (hwdata),
		.hwrite (hwrite),
		.hready (hready)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		hready = 1'b1;
		forever
		begin
			@(negedge clk);
			hready = stall_mode ? 1'($urandom) : 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// memory model
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (seen_epoch != log_epoch)
		begin
			draw_mem.delete();
			clear_mem.delete();
			total_writes    = 0;
			draw_writes     = 0;
			clear_writes    = 0;
			top_byte_writes = 0;
			seen_epoch      = log_epoch;
		end
		if (!reset && hwrite && hready)
		begin
			total_writes++;
			if (hwdata[31:24] != 8'd0)
				top_byte_writes++;
			if (hwdata == '0)
			begin
				clear_writes++;
				clear_mem[haddr] = 1'b1;
			end
			else
			begin
				draw_writes++;
				draw_mem[haddr] = hwdata[23:0];
			end
		end
	end

	function automatic point_t pt(int x, int y);
		point_t p;
		p.x = 9'(x);
		p.y = 8'(y);
		return p;
	endfunction

	// each field wraps at its own width
	function automatic point_t move_point(point_t p, point_t d);
		point_t r;
		r.x = p.x + d.x;
		r.y = p.y + d.y;
		return r;
	endfunction

	function automatic status_t make_status(logic front, logic clear_busy, logic line_busy);
		status_t s;
		s.front      = front;
		s.clear_busy = clear_busy;
		s.line_busy  = line_busy;
		return s;
	endfunction

	function automatic logic [31:0] pixel_addr(logic [31:0] base, int x, int y);
		return base + 32'((y * `GPU_WIDTH + x) * 4);
	endfunction

	function automatic logic [31:0] back_base();
		return exp_front ? `GPU_BUF0_BASE : `GPU_BUF1_BASE;
	endfunction

	// integer Bresenham over all octants including both end points
	task automatic ref_line(input point_t p0, input point_t p1, input logic [31:0] base);
		int x;
		int y;
		int x1;
		int y1;
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		int steps;
		x  = int'(p0.x);
		y  = int'(p0.y);
		x1 = int'(p1.x);
		y1 = int'(p1.y);
		dx = (x1 > x) ? x1 - x : x - x1;
		dy = (y1 > y) ? y1 - y : y - y1;
		sx = (x < x1) ? 1 : -1;
		sy = (y < y1) ? 1 : -1;
		err = dx - dy;
		steps = 0;
		ref_addr.delete();
		while (steps < 2000)
		begin
			ref_addr.push_back(pixel_addr(base, x, y));
			if ((x == x1) && (y == y1))
				break;
			e2 = 2 * err;
			if (e2 > -dy)
			begin
				err -= dy;
				x += sx;
			end
			if (e2 < dx)
			begin
				err += dx;
				y += sy;
			end
			steps++;
		end
	endtask

	task automatic check_status(string name, status_t exp, status_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected status %b, got %b", name, exp, act);
			check_errors++;
		end
	endtask

	task automatic check_color(string name, color_t exp, color_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected color %h, got %h", name, exp, act);
			check_errors++;
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp)
		begin
			$display("Fail %s: expected %0d, got %0d", name, exp, act);
			check_errors++;
		end
	endtask

	task automatic end_run();
		$display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
		if ((check_errors == 0) && (timeouts == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// host port and waits
	//////////////////////////////////////////////////

	task automatic send_cmd(gpu_opcode_e op, logic [23:0] data);
		psel   = 1'b0; // one low cycle so the command edge is seen
		pwrite = 1'b0;
		@(negedge clk);
		psel   = 1'b1;
		pwrite = 1'b1;
		pwdata = {5'd0, op, data};
		repeat (2) @(negedge clk);
		psel   = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
	endtask

	task automatic read_status(output status_t st);
		psel   = 1'b1;
		pwrite = 1'b0;
		@(negedge clk);
		st   = status_t'(prdata[2:0]);
		psel = 1'b0;
	endtask

	task automatic wait_idle(string name);
		status_t st;
		int      polls;
		polls = 0;
		read_status(st);
		while ((st.line_busy || st.clear_busy) && (polls < WAIT_LIMIT))
		begin
			polls++;
			read_status(st);
		end
		if (st.line_busy || st.clear_busy)
		begin
			$display("%s: the engines were still busy after %0d status reads", name, WAIT_LIMIT);
			timeouts++;
		end
	endtask

	task automatic wait_bus_idle(string name);
		int cycles;
		cycles = 0;
		while (hwrite && (cycles < 1000))
		begin
			@(negedge clk);
			cycles++;
		end
		if (hwrite)
		begin
			$display("%s: the last bus write never completed", name);
			timeouts++;
		end
	endtask

	task automatic clear_log();
		log_epoch++;
		@(negedge clk);
	endtask

	task automatic check_line(string name, point_t p0, point_t p1, color_t col);
		int missing;
		missing = 0;
		ref_line(p0, p1, back_base());
		check_count({name, " write count"}, ref_addr.size(), draw_writes);
		check_count({name, " pixel count"}, ref_addr.size(), draw_mem.num());
		check_count({name, " top byte writes"}, 0, top_byte_writes);
		foreach (ref_addr[i])
		begin
			if (draw_mem.exists(ref_addr[i]))
				check_color(name, col, draw_mem[ref_addr[i]]);
			else
				missing++;
		end
		if (missing != 0)
		begin
			$display("%s: %0d pixels of the line were never written", name, missing);
			check_errors++;
		end
	endtask

	task automatic draw_line(string name, point_t p0, point_t p1, color_t col);
		clear_log();
		send_cmd(OP_SET_COLOR, col);
		send_cmd(OP_SET_START, {7'd0, p0});
		send_cmd(OP_SET_END, {7'd0, p1});
		send_cmd(OP_DRAW, 24'd0);
		wait_idle(name);
		wait_bus_idle(name);
		check_line(name, p0, p1, col);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		status_t st;
		read_status(st);
		check_status("reset status", make_status(1'b0, 1'b0, 1'b0), st);
		repeat (10) @(negedge clk);
		check_count("reset idle writes", 0, total_writes);
	endtask

	task automatic test_draws();
		draw_line("horizontal", pt(10, 5), pt(40, 5), 24'hff0000);
		draw_line("vertical", pt(7, 3), pt(7, 30), 24'h00ff00);
		draw_line("steep", pt(20, 10), pt(27, 60), 24'h0000ff);
		draw_line("reversed", pt(300, 200), pt(250, 180), 24'h808080);
		draw_line("reversed steep", pt(150, 120), pt(140, 60), 24'h00a5ff);
	endtask

	task automatic test_move();
		point_t s;
		point_t e;
		point_t ds;
		point_t de;
		s  = pt(10, 20);
		e  = pt(100, 50);
		ds = pt(5, 253);  // y moves by -3
		de = pt(502, 4);  // x moves by -10
		clear_log();
		send_cmd(OP_SET_COLOR, 24'h123456);
		send_cmd(OP_SET_START, {7'd0, s});
		send_cmd(OP_SET_END, {7'd0, e});
		send_cmd(OP_MOVE_START, {7'd0, ds});
		send_cmd(OP_MOVE_END, {7'd0, de});
		send_cmd(OP_DRAW, 24'd0);
		wait_idle("move");
		wait_bus_idle("move");
		check_line("move", move_point(s, ds), move_point(e, de), 24'h123456);
	endtask

	task automatic test_flip();
		status_t st;
		send_cmd(OP_FLIP, 24'd0);
		read_status(st);
		check_status("flip", make_status(1'b1, 1'b0, 1'b0), st);
		exp_front = 1'b1;
		draw_line("draw after flip", pt(200, 100), pt(230, 140), 24'h0000ff);
		send_cmd(OP_FLIP, 24'd0);
		read_status(st);
		check_status("flip back", make_status(1'b0, 1'b0, 1'b0), st);
		exp_front = 1'b0;
	endtask

	task automatic test_clear_stall();
		int          in_range;
		logic [31:0] base;
		clear_log();
		stall_mode = 1'b1;
		send_cmd(OP_SET_COLOR, 24'h00ff00);
		send_cmd(OP_SET_START, {7'd0, pt(50, 50)});
		send_cmd(OP_SET_END, {7'd0, pt(10, 90)});
		send_cmd(OP_CLEAR, 24'd0);
		send_cmd(OP_DRAW, 24'd0); // runs alongside the clear
		wait_idle("clear with draw");
		wait_bus_idle("clear with draw");
		stall_mode = 1'b0;
		base = back_base();
		in_range = 0;
		foreach (clear_mem[a])
		begin
			if ((a >= base) && (a < base + 32'(FRAME_PIXELS * 4)))
				in_range++;
		end
		check_count("clear write count", FRAME_PIXELS, clear_writes);
		check_count("clear coverage", FRAME_PIXELS, in_range);
		check_line("draw during clear", pt(50, 50), pt(10, 90), 24'h00ff00);
	endtask

	task automatic test_ignore();
		status_t st;
		clear_log();
		send_cmd(OP_SET_COLOR, 24'hffff00);
		send_cmd(OP_SET_START, {7'd0, pt(0, 0)});
		send_cmd(OP_SET_END, {7'd0, pt(300, 100)});
		send_cmd(OP_DRAW, 24'd0);
		send_cmd(OP_SET_END, {7'd0, pt(5, 5)});
		send_cmd(OP_DRAW, 24'd0);
		send_cmd(OP_FLIP, 24'd0);
		read_status(st);
		check_status("busy draw", make_status(1'b0, 1'b0, 1'b1), st);
		wait_idle("ignored draw");
		wait_bus_idle("ignored draw");
		check_line("ignored draw", pt(0, 0), pt(300, 100), 24'hffff00);

		clear_log();
		send_cmd(OP_CLEAR, 24'd0);
		send_cmd(OP_CLEAR, 24'd0);
		send_cmd(OP_FLIP, 24'd0);
		read_status(st);
		check_status("busy clear", make_status(1'b0, 1'b1, 1'b0), st);
		wait_idle("ignored clear");
		wait_bus_idle("ignored clear");
		check_count("single clear", FRAME_PIXELS, clear_writes);
		check_count("no line writes", 0, draw_writes);
		read_status(st);
		check_status("after clear", make_status(1'b0, 1'b0, 1'b0), st);
	endtask

	initial
	begin
		void'($urandom(32'h4844dd8d));
		reset      = 1'b1;
		psel       = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		stall_mode = 1'b0;
		exp_front  = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		test_reset();
		test_draws();
		test_move();
		test_flip();
		test_clear_stall();
		test_ignore();
		end_run();
	end

endmodule
